//--- hdl/udp_reg_cfg.svh
/*
 * configuration of the udp register bank
 * local address, accepted port, register geometry and reply format
 * include wherever one of these values is needed
 */
`ifndef UDP_REG_CFG_SVH
`define UDP_REG_CFG_SVH

// own ip address, used as source of every reply
`define UDP_LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}

// only this destination port carries commands
`define UDP_PORT_NBR 16'd1234

// register bank geometry
`define UDP_REGS_NUM 4
`define UDP_REG_WIDTH 32

// ttl placed in the reply header
`define UDP_TTL 8'd64

// opcode, index and four value bytes
`define UDP_REPLY_BYTES 6

`endif

//--- hdl/udp_reg_pkg.sv
/*
 * types shared by the register bank rtl and its testbench
 * opcodes, stream beats, command and response records, reply header
 */
`include "udp_reg_cfg.svh"

package udp_reg_pkg;

  // command opcodes, OP_BAD also marks an index out of range
  typedef enum logic [7:0] {
    OP_WRITE = 8'h01,
    OP_READ  = 8'h02,
    OP_BAD   = 8'hFF
  } op_e;

  // header fields delivered with each received packet
  typedef struct packed {
    logic [31:0] source_ip;
    logic [15:0] source_port;
    logic [15:0] dest_port;
  } rx_meta_t;

  // one payload byte plus end of packet
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } stream_beat_t;

  typedef struct packed {
    op_e                       op;
    logic [7:0]                idx;
    logic [`UDP_REG_WIDTH-1:0] wdata;
    rx_meta_t                  meta;
  } cmd_t;

  typedef struct packed {
    op_e                       op;
    logic [7:0]                idx;
    logic [`UDP_REG_WIDTH-1:0] value;
    rx_meta_t                  meta;
  } rsp_t;

  // reply header handed to the udp stack
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [7:0]  ttl;
  } tx_hdr_t;

  typedef logic [`UDP_REGS_NUM-1:0][`UDP_REG_WIDTH-1:0] reg_array_t;

  // active-low segment patterns, digit 0 is the lowest nibble
  typedef logic [7:0][6:0] hex_digits_t;

endpackage

//--- hdl/cmd_parser.sv
/*
 * receive side of the register bank
 * filters packets on destination port, collects command bytes and
 * emits one decoded command per complete packet
 */
`include "udp_reg_cfg.svh"

module cmd_parser (
  input  logic                      clk,
  input  logic                      rst,
  input  udp_reg_pkg::rx_meta_t     i_rx_meta,
  input  logic                      i_rx_valid,
  input  udp_reg_pkg::stream_beat_t i_rx_beat,
  output logic                      o_rx_ready,
  input  logic                      i_busy,
  output logic                      o_cmd_valid,
  output udp_reg_pkg::cmd_t         o_cmd,
  output logic                      o_first_valid,
  output logic [7:0]                o_first_byte,
  output logic [31:0]               o_src_ip
);
  import udp_reg_pkg::*;

  typedef enum logic [1:0] {IDLE, COLLECT, DROP} state_e;

  state_e     state_q;
  // bytes seen so far, saturates at 6
  logic [2:0] cnt_q;
  logic [7:0] op_raw_q;
  logic       beat_fire;
  logic [7:0] idx_n;
  op_e        op_n;
  logic       pkt_ok;

  // stall from the command pulse until the reply is gone
  assign o_rx_ready = ~(o_cmd_valid | i_busy);
  assign beat_fire  = i_rx_valid & o_rx_ready;

  // first beat of every packet, dropped ones too
  assign o_first_valid = beat_fire & (state_q == IDLE);
  assign o_first_byte  = i_rx_beat.data;
  assign o_src_ip      = i_rx_meta.source_ip;

  // index may arrive in the same beat as last
  assign idx_n = (cnt_q == 3'd1) ? i_rx_beat.data : o_cmd.idx;

  // single decode point for opcode and index range
  always_comb begin
    if ((op_raw_q == OP_WRITE || op_raw_q == OP_READ) && idx_n < `UDP_REGS_NUM) begin
      op_n = op_e'(op_raw_q);
    end else begin
      op_n = OP_BAD;
    end
  end

  // a write needs all six bytes, anything else two
  assign pkt_ok = (op_raw_q != OP_WRITE) || (cnt_q >= 3'd5);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      cnt_q       <= '0;
      o_cmd_valid <= 1'b0;
    end else begin
      o_cmd_valid <= 1'b0;
      if (beat_fire) begin
        case (state_q)
          IDLE: begin
            cnt_q <= 3'd1;
            if (i_rx_meta.dest_port != `UDP_PORT_NBR) begin
              state_q <= i_rx_beat.last ? IDLE : DROP;
            end else if (!i_rx_beat.last) begin
              state_q <= COLLECT;
            end
          end
          COLLECT: begin
            if (cnt_q != 3'd6) begin
              cnt_q <= cnt_q + 3'd1;
            end
            if (i_rx_beat.last) begin
              state_q     <= IDLE;
              o_cmd_valid <= pkt_ok;
            end
          end
          default: begin
            // wrong port, swallow until end of packet
            if (i_rx_beat.last) begin
              state_q <= IDLE;
            end
          end
        endcase
      end
    end
  end

  // command fields fill in as bytes arrive
  always_ff @(posedge clk) begin
    if (beat_fire && state_q == IDLE) begin
      op_raw_q   <= i_rx_beat.data;
      o_cmd.meta <= i_rx_meta;
    end
    if (beat_fire && state_q == COLLECT) begin
      if (cnt_q == 3'd1) begin
        o_cmd.idx <= i_rx_beat.data;
      end
      // write data msb first, bytes past the sixth ignored
      if (cnt_q >= 3'd2 && cnt_q <= 3'd5) begin
        o_cmd.wdata <= {o_cmd.wdata[`UDP_REG_WIDTH-9:0], i_rx_beat.data};
      end
      if (i_rx_beat.last) begin
        o_cmd.op <= op_n;
      end
    end
  end

endmodule

//--- hdl/reg_bank.sv
/*
 * register bank
 * executes one write or read per command pulse and issues a response
 * record one cycle later, registers are visible to the display
 */
`include "udp_reg_cfg.svh"

module reg_bank (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_cmd_valid,
  input  udp_reg_pkg::cmd_t       i_cmd,
  output logic                    o_rsp_valid,
  output udp_reg_pkg::rsp_t       o_rsp,
  output udp_reg_pkg::reg_array_t o_regs
);
  import udp_reg_pkg::*;

  localparam int IDX_W = $clog2(`UDP_REGS_NUM);

  logic [IDX_W-1:0] idx;

  // range already checked by the parser unless op is OP_BAD
  assign idx = i_cmd.idx[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      o_regs      <= '0;
      o_rsp_valid <= 1'b0;
    end else begin
      o_rsp_valid <= i_cmd_valid;
      if (i_cmd_valid && i_cmd.op == OP_WRITE) begin
        o_regs[idx] <= i_cmd.wdata;
      end
    end
  end

  // response carries the value after the operation
  always_ff @(posedge clk) begin
    if (i_cmd_valid) begin
      o_rsp.op   <= i_cmd.op;
      o_rsp.idx  <= i_cmd.idx;
      o_rsp.meta <= i_cmd.meta;
      if (i_cmd.op == OP_BAD) begin
        o_rsp.value <= '0;
      end else if (i_cmd.op == OP_WRITE) begin
        o_rsp.value <= i_cmd.wdata;
      end else begin
        o_rsp.value <= o_regs[idx];
      end
    end
  end

endmodule

//--- hdl/reply_gen.sv
/*
 * transmit side of the register bank
 * presents the swapped reply header, then serializes the fixed-size
 * payload, every header and beat held until accepted
 */
`include "udp_reg_cfg.svh"

module reply_gen (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_rsp_valid,
  input  udp_reg_pkg::rsp_t         i_rsp,
  output logic                      o_busy,
  output logic                      o_tx_hdr_valid,
  output udp_reg_pkg::tx_hdr_t      o_tx_hdr,
  input  logic                      i_tx_hdr_ready,
  output logic                      o_tx_valid,
  output udp_reg_pkg::stream_beat_t o_tx_beat,
  input  logic                      i_tx_ready
);
  import udp_reg_pkg::*;

  localparam int CNT_W   = $clog2(`UDP_REPLY_BYTES);
  localparam int PLD_W   = 8 * `UDP_REPLY_BYTES;
  localparam int LAST_IX = `UDP_REPLY_BYTES - 1;

  typedef enum logic [1:0] {IDLE, HDR, DATA} state_e;

  state_e           state_q;
  logic [CNT_W-1:0] cnt_q;
  rsp_t             rsp_q;
  logic [PLD_W-1:0] payload;
  logic             beat_last;

  // busy spans the response pulse too, so the parser never sees a gap
  assign o_busy = i_rsp_valid | (state_q != IDLE);

  assign o_tx_hdr_valid = (state_q == HDR);
  assign o_tx_valid     = (state_q == DATA);

  // opcode, index, value msb first
  assign payload   = {rsp_q.op, rsp_q.idx, rsp_q.value};
  assign beat_last = (cnt_q == LAST_IX[CNT_W-1:0]);

  // addresses and ports swapped back to the sender
  always_comb begin
    o_tx_hdr.src_ip   = `UDP_LOCAL_IP;
    o_tx_hdr.dst_ip   = rsp_q.meta.source_ip;
    o_tx_hdr.src_port = rsp_q.meta.dest_port;
    o_tx_hdr.dst_port = rsp_q.meta.source_port;
    o_tx_hdr.length   = 16'(8 + `UDP_REPLY_BYTES);
    o_tx_hdr.ttl      = `UDP_TTL;
  end

  always_comb begin
    o_tx_beat.data = payload[(LAST_IX - cnt_q) * 8 +: 8];
    o_tx_beat.last = beat_last;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (i_rsp_valid) begin
            state_q <= HDR;
          end
        end
        HDR: begin
          cnt_q <= '0;
          if (i_tx_hdr_ready) begin
            state_q <= DATA;
          end
        end
        default: begin
          if (i_tx_ready) begin
            cnt_q <= cnt_q + 1'b1;
            if (beat_last) begin
              state_q <= IDLE;
            end
          end
        end
      endcase
    end
  end

  // response record stays put until the last beat leaves
  always_ff @(posedge clk) begin
    if (i_rsp_valid && state_q == IDLE) begin
      rsp_q <= i_rsp;
    end
  end

endmodule

//--- hdl/display_ctrl.sv
/*
 * board display logic
 * first payload byte of each packet on the green leds, a switch
 * selected register or the last sender ip on eight hex digits
 */
`include "udp_reg_cfg.svh"

module display_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [3:0]               i_sw,
  input  udp_reg_pkg::reg_array_t  i_regs,
  input  logic                     i_first_valid,
  input  logic [7:0]               i_first_byte,
  input  logic [31:0]              i_src_ip,
  output logic [7:0]               o_ledg,
  output udp_reg_pkg::hex_digits_t o_hex
);
  import udp_reg_pkg::*;

  localparam int         IDX_W    = $clog2(`UDP_REGS_NUM);
  // inverted pattern of digit 0
  localparam logic [6:0] SEG_ZERO = 7'h40;

  logic [31:0] ip_q;
  logic [31:0] disp_val;
  hex_digits_t hex_d;

  // active-high gfedcba pattern
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    case (nib)
      4'h0: seg7 = 7'h3F;
      4'h1: seg7 = 7'h06;
      4'h2: seg7 = 7'h5B;
      4'h3: seg7 = 7'h4F;
      4'h4: seg7 = 7'h66;
      4'h5: seg7 = 7'h6D;
      4'h6: seg7 = 7'h7D;
      4'h7: seg7 = 7'h07;
      4'h8: seg7 = 7'h7F;
      4'h9: seg7 = 7'h6F;
      4'hA: seg7 = 7'h77;
      4'hB: seg7 = 7'h7C;
      4'hC: seg7 = 7'h39;
      4'hD: seg7 = 7'h5E;
      4'hE: seg7 = 7'h79;
      default: seg7 = 7'h71;
    endcase
  endfunction

  // registers first, then the sender ip, blank otherwise
  always_comb begin
    if (i_sw < `UDP_REGS_NUM) begin
      disp_val = i_regs[i_sw[IDX_W-1:0]];
    end else if (i_sw == `UDP_REGS_NUM) begin
      disp_val = ip_q;
    end else begin
      disp_val = '0;
    end
  end

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      hex_d[i] = ~seg7(disp_val[i*4 +: 4]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_ledg <= '0;
      ip_q   <= '0;
      o_hex  <= {8{SEG_ZERO}};
    end else begin
      o_hex <= hex_d;
      if (i_first_valid) begin
        o_ledg <= i_first_byte;
        ip_q   <= i_src_ip;
      end
    end
  end

endmodule

//--- hdl/udp_reg_top.sv
/*
 * udp register bank top level
 * sits where the user logic of the udp stack goes, parser, register
 * bank, reply generator and display wired in a chain
 */
module udp_reg_top (
  input  logic                      clk,
  input  logic                      rst,
  // received udp packet
  input  udp_reg_pkg::rx_meta_t     i_rx_meta,
  input  logic                      i_rx_valid,
  input  udp_reg_pkg::stream_beat_t i_rx_beat,
  output logic                      o_rx_ready,
  // reply header and payload
  output logic                      o_tx_hdr_valid,
  output udp_reg_pkg::tx_hdr_t      o_tx_hdr,
  input  logic                      i_tx_hdr_ready,
  output logic                      o_tx_valid,
  output udp_reg_pkg::stream_beat_t o_tx_beat,
  input  logic                      i_tx_ready,
  // board io
  input  logic [3:0]                i_sw,
  output logic [7:0]                o_ledg,
  output udp_reg_pkg::hex_digits_t  o_hex
);
  import udp_reg_pkg::*;

  logic        cmd_valid;
  cmd_t        cmd;
  logic        rsp_valid;
  rsp_t        rsp;
  logic        busy;
  reg_array_t  regs;
  logic        first_valid;
  logic [7:0]  first_byte;
  logic [31:0] src_ip;

  cmd_parser u_cmd_parser (
    .clk           (clk),
    .rst           (rst),
    .i_rx_meta     (i_rx_meta),
    .i_rx_valid    (i_rx_valid),
    .i_rx_beat     (i_rx_beat),
    .o_rx_ready    (o_rx_ready),
    .i_busy        (busy),
    .o_cmd_valid   (cmd_valid),
    .o_cmd         (cmd),
    .o_first_valid (first_valid),
    .o_first_byte  (first_byte),
    .o_src_ip      (src_ip)
  );

  reg_bank u_reg_bank (
    .clk         (clk),
    .rst         (rst),
    .i_cmd_valid (cmd_valid),
    .i_cmd       (cmd),
    .o_rsp_valid (rsp_valid),
    .o_rsp       (rsp),
    .o_regs      (regs)
  );

  reply_gen u_reply_gen (
    .clk            (clk),
    .rst            (rst),
    .i_rsp_valid    (rsp_valid),
    .i_rsp          (rsp),
    .o_busy         (busy),
    .o_tx_hdr_valid (o_tx_hdr_valid),
    .o_tx_hdr       (o_tx_hdr),
    .i_tx_hdr_ready (i_tx_hdr_ready),
    .o_tx_valid     (o_tx_valid),
    .o_tx_beat      (o_tx_beat),
    .i_tx_ready     (i_tx_ready)
  );

  display_ctrl u_display_ctrl (
    .clk           (clk),
    .rst           (rst),
    .i_sw          (i_sw),
    .i_regs        (regs),
    .i_first_valid (first_valid),
    .i_first_byte  (first_byte),
    .i_src_ip      (src_ip),
    .o_ledg        (o_ledg),
    .o_hex         (o_hex)
  );

endmodule

//--- test/tb_udp_reg_top.sv
/*
 * testbench for the udp register bank
 * replays the packets of the stimulus file against the DUT, stalls the
 * reply path at random and checks replies, leds and hex digits
 */
`include "udp_reg_cfg.svh"

module tb_udp_reg_top;
  import udp_reg_pkg::*;

  localparam int CLK_PERIOD  = 100;
  // words per stimulus record
  localparam int WORDS       = 12;
  localparam int MAX_VEC     = 32;
  localparam int REPLY_LIMIT = 100;
  localparam int LAST_BEAT   = `UDP_REPLY_BYTES - 1;
  // inverted gfedcba codes, digit F first
  localparam logic [15:0][6:0] SEG_INV = {
    7'h0E, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h10, 7'h00,
    7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40
  };

  logic         clk;
  logic         rst;
  rx_meta_t     i_rx_meta;
  logic         i_rx_valid;
  stream_beat_t i_rx_beat;
  logic         o_rx_ready;
  logic         o_tx_hdr_valid;
  tx_hdr_t      o_tx_hdr;
  logic         i_tx_hdr_ready;
  logic         o_tx_valid;
  stream_beat_t o_tx_beat;
  logic         i_tx_ready;
  logic [3:0]   i_sw;
  logic [7:0]   o_ledg;
  hex_digits_t  o_hex;

  logic [31:0]  stim [0:WORDS*MAX_VEC-1];
  int           n_vec = 0;
  int           checks = 0;
  int           errors = 0;
  // completed replies seen by the monitor and by the main flow
  int           done_cnt = 0;
  int           done_seen = 0;
  logic         want_reply;
  logic         reply_due;
  logic [31:0]  rnd;
  tx_hdr_t      hdr_q[$];
  stream_beat_t beat_q[$];

  udp_reg_top u_udp_reg_top (
    .clk            (clk),
    .rst            (rst),
    .i_rx_meta      (i_rx_meta),
    .i_rx_valid     (i_rx_valid),
    .i_rx_beat      (i_rx_beat),
    .o_rx_ready     (o_rx_ready),
    .o_tx_hdr_valid (o_tx_hdr_valid),
    .o_tx_hdr       (o_tx_hdr),
    .i_tx_hdr_ready (i_tx_hdr_ready),
    .o_tx_valid     (o_tx_valid),
    .o_tx_beat      (o_tx_beat),
    .i_tx_ready     (i_tx_ready),
    .i_sw           (i_sw),
    .o_ledg         (o_ledg),
    .o_hex          (o_hex)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // eight digits, digit 0 from the lowest nibble
  function automatic logic [55:0] hex_expect(input logic [31:0] val);
    logic [55:0] r;
    for (int i = 0; i < 8; i++) begin
      r[i*7 +: 7] = SEG_INV[val[i*4 +: 4]];
    end
    return r;
  endfunction

  // payload bytes packed msb first over two words
  function automatic logic [7:0] payload_byte(input int base, input int b);
    logic [63:0] pay;
    pay = {stim[base+4], stim[base+5]};
    return pay[63 - 8*b -: 8];
  endfunction

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // hold the beat until a cycle with ready high
  task automatic send_beat(input logic [7:0] data, input logic last);
    logic took;
    i_rx_valid <= 1'b1;
    i_rx_beat  <= '{data: data, last: last};
    took = 1'b0;
    while (!took) begin
      @(negedge clk);
      took = o_rx_ready;
      @(posedge clk);
    end
  endtask

  task automatic wait_reply(input string tname, input int base);
    int           waited;
    tx_hdr_t      hdr_exp;
    tx_hdr_t      hdr;
    stream_beat_t beat;
    logic [47:0]  pay_exp;
    waited = 0;
    while (done_cnt == done_seen && waited < REPLY_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (done_cnt == done_seen) begin
      errors++;
      $display("timeout: %s got no complete reply in %0d cycles", tname, REPLY_LIMIT);
    end else begin
      done_seen++;
      // addresses and ports swapped, 192.168.1.128 as source
      // udp length of 14 and ttl of 64
      hdr_exp.src_ip   = 32'hC0A80180;
      hdr_exp.dst_ip   = stim[base+1];
      hdr_exp.src_port = stim[base][15:0];
      hdr_exp.dst_port = stim[base+2][15:0];
      hdr_exp.length   = 16'd14;
      hdr_exp.ttl      = 8'd64;
      pay_exp = {stim[base+8][15:0], stim[base+9]};
      check_value($sformatf("%s hdr count", tname), 1, hdr_q.size());
      check_value($sformatf("%s beat count", tname), `UDP_REPLY_BYTES, beat_q.size());
      if (hdr_q.size() > 0) begin
        hdr = hdr_q.pop_front();
        check_value($sformatf("%s hdr", tname), hdr_exp, hdr);
      end
      for (int i = 0; i < `UDP_REPLY_BYTES && beat_q.size() > 0; i++) begin
        beat = beat_q.pop_front();
        check_value($sformatf("%s beat%0d", tname, i),
                    {pay_exp[47 - 8*i -: 8], i == LAST_BEAT}, beat);
      end
    end
    hdr_q.delete();
    beat_q.delete();
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // random stalls on header and payload ready
  always @(posedge clk) begin
    rnd = xorshift(rnd);
    i_tx_hdr_ready <= rnd[0];
    i_tx_ready     <= rnd[7];
  end

  // records reply transfers and watches rx_ready while a reply is due
  always @(negedge clk) begin
    if (reply_due) begin
      check_value("rx_ready low during reply", 0, o_rx_ready);
    end
    if (o_tx_hdr_valid && i_tx_hdr_ready) begin
      hdr_q.push_back(o_tx_hdr);
    end
    if (o_tx_valid && i_tx_ready) begin
      beat_q.push_back(o_tx_beat);
      if (o_tx_beat.last) begin
        done_cnt++;
        reply_due = 1'b0;
      end
    end
    if (i_rx_valid && o_rx_ready && i_rx_beat.last && want_reply) begin
      reply_due = 1'b1;
    end
  end

  initial begin
    int    base;
    int    nbytes;
    string tname;
    rst            = 1'b1;
    i_rx_meta      = '0;
    i_rx_valid     = 1'b0;
    i_rx_beat      = '0;
    i_tx_hdr_ready = 1'b0;
    i_tx_ready     = 1'b0;
    i_sw           = '0;
    want_reply     = 1'b0;
    reply_due      = 1'b0;
    rnd            = 32'h8574;
    // all-ones dest port word marks the end of the records
    foreach (stim[i]) begin
      stim[i] = '1;
    end
    $readmemh("test/udp_reg_stim.txt", stim);
    while (n_vec < MAX_VEC && stim[n_vec*WORDS] !== 32'hFFFFFFFF) begin
      n_vec++;
    end
    if (n_vec == 0) begin
      errors++;
      $display("stimulus file test/udp_reg_stim.txt is missing or holds no vectors");
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("reset rx_ready", 1, o_rx_ready);
    check_value("reset tx valid", 0, {o_tx_hdr_valid, o_tx_valid});
    check_value("reset ledg", 0, o_ledg);
    check_value("reset hex", hex_expect(32'h0), o_hex);
    @(posedge clk);
    for (int v = 0; v < n_vec; v++) begin
      base   = v * WORDS;
      tname  = $sformatf("vec%0d", v);
      nbytes = stim[base+3];
      i_rx_meta <= '{source_ip: stim[base+1], source_port: stim[base+2][15:0],
                     dest_port: stim[base][15:0]};
      i_sw <= stim[base+6][3:0];
      want_reply = stim[base+7][0];
      for (int b = 0; b < nbytes; b++) begin
        send_beat(payload_byte(base, b), b == nbytes - 1);
      end
      i_rx_valid <= 1'b0;
      if (want_reply) begin
        wait_reply(tname, base);
      end else begin
        // header would be out 3 cycles after the last beat
        repeat (8) @(posedge clk);
        check_value($sformatf("%s no reply", tname), 0, hdr_q.size() + beat_q.size());
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_value($sformatf("%s ledg", tname), stim[base+11][7:0], o_ledg);
      check_value($sformatf("%s hex", tname), hex_expect(stim[base+10]), o_hex);
      @(posedge clk);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // 200 cycles per vector
  initial begin
    wait (n_vec > 0);
    #(n_vec * 200 * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", n_vec * 200);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- test/udp_reg_stim.txt
// dport sip sport nbytes pay0-3 pay4-7 sw reply_flag reply_op_idx reply_value disp_value ledg
// one packet per line, all hex, reply_flag 0 means no reply expected
04D2 C0A80105 1F90 6 0101DEAD BEEF0000 1 1 0101 DEADBEEF DEADBEEF 01
04D2 C0A80105 1F90 2 02010000 00000000 4 1 0201 DEADBEEF C0A80105 02
0050 C0A80107 1F91 6 01011111 11110000 1 0 0000 00000000 DEADBEEF 01
04D2 C0A80108 2000 4 01020304 00000000 4 0 0000 00000000 C0A80108 01
04D2 C0A80108 2000 2 02020000 00000000 2 1 0202 00000000 00000000 02
04D2 C0A80108 2000 2 07030000 00000000 5 1 FF03 00000000 00000000 07
04D2 C0A80108 2000 2 02040000 00000000 1 1 FF04 00000000 DEADBEEF 02
04D2 C0A80108 2000 6 01091234 56780000 7 1 FF09 00000000 00000000 01
04D2 C0A80109 2001 8 01030123 ABCDEEFF 3 1 0103 0123ABCD 0123ABCD 01
04D2 0A000001 3039 6 0100CAFE F00D0000 0 1 0100 CAFEF00D CAFEF00D 01
04D2 0A000002 303A 2 02030000 00000000 4 1 0203 0123ABCD 0A000002 02
04D3 C0A8010A 1F92 1 A5000000 00000000 4 0 0000 00000000 C0A8010A A5
04D2 C0A8010B 1F93 1 02000000 00000000 2 0 0000 00000000 00000000 02
04D2 C0A8010C 1F94 2 02010000 00000000 F 1 0201 DEADBEEF 00000000 02

//--- src.f
+incdir+hdl
hdl/udp_reg_pkg.sv
hdl/cmd_parser.sv
hdl/reg_bank.sv
hdl/reply_gen.sv
hdl/display_ctrl.sv
hdl/udp_reg_top.sv
test/tb_udp_reg_top.sv

//--- Bender.yml
package:
  name: udp_reg

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/udp_reg_pkg.sv
      - hdl/cmd_parser.sv
      - hdl/reg_bank.sv
      - hdl/reply_gen.sv
      - hdl/display_ctrl.sv
      - hdl/udp_reg_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_udp_reg_top.sv
